/* hw/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_W 32
`define REG_N 32

// Opcodes
`define OP_RTYPE 6'h00
`define OP_ADDI 6'h08
`define OP_J 6'h02
`define OP_JAL 6'h03

// R-type funct codes
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLT 6'h2A
`define FN_JR 6'h08
`define FN_DIV 6'h1A
`define FN_MFHI 6'h10
`define FN_MFLO 6'h12

`define LINK_REG 5'd31 // Return address for jal

`endif

/* hw/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [$clog2(`REG_N)-1:0] regAddr_t;
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;

  typedef logic [2:0] aluOp_t;
  localparam aluOp_t PASS_A = 3'd0;
  localparam aluOp_t ADD = 3'd1;
  localparam aluOp_t SUB = 3'd2;
  localparam aluOp_t AND = 3'd3;
  localparam aluOp_t SLT = 3'd4;

  typedef enum logic [3:0] {
    RESET, FETCH0, FETCH1, DECODE, READREGS, EXECUTE,
    WRITEBACK, JUMP, DIVSTART, DIVWAIT, DIVSAVE, MOVEHILO
  } ctrlState_t;

  typedef logic [1:0] pcSel_t;
  localparam pcSel_t PC_PLUS4 = 2'd0; // ALUOut holds PC+4 after fetch
  localparam pcSel_t PC_JUMP = 2'd1;
  localparam pcSel_t PC_REG = 2'd2;

  typedef logic [1:0] wbSel_t;
  localparam wbSel_t WB_ALU = 2'd0;
  localparam wbSel_t WB_HI = 2'd1;
  localparam wbSel_t WB_LO = 2'd2;
  localparam wbSel_t WB_LINK = 2'd3;

  typedef logic [1:0] srcBSel_t;
  localparam srcBSel_t SRCB_REG = 2'd0;
  localparam srcBSel_t SRCB_FOUR = 2'd1;
  localparam srcBSel_t SRCB_IMM = 2'd2;

endpackage

/* hw/controlUnit.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module controlUnit (
  input  logic              clk,
  input  logic              reset_in,
  input  cpu_pkg::opcode_t  opcode,
  input  cpu_pkg::funct_t   funct,
  input  logic              divDone,
  output logic              irWe,
  output logic              pcWe,
  output logic              abWe,
  output logic              aluOutWe,
  output logic              hiLoWe,
  output logic              regWe,
  output logic              divStart,
  output cpu_pkg::pcSel_t   pcSel,
  output logic              srcASel,
  output cpu_pkg::srcBSel_t srcBSel,
  output cpu_pkg::wbSel_t   wbSel,
  output cpu_pkg::aluOp_t   aluOp
);
  import cpu_pkg::*;

  ctrlState_t state;
  ctrlState_t nextState;
  logic isRtype;
  logic isAddi;
  logic isJ;
  logic isJal;
  logic isAluR;
  logic isJr;
  logic isDiv;
  logic isMove;
  aluOp_t execOp;

  assign isRtype = (opcode == `OP_RTYPE);
  assign isAddi = (opcode == `OP_ADDI);
  assign isJ = (opcode == `OP_J);
  assign isJal = (opcode == `OP_JAL);
  assign isAluR = isRtype && (funct == `FN_ADD || funct == `FN_SUB ||
                              funct == `FN_AND || funct == `FN_SLT);
  assign isJr = isRtype && (funct == `FN_JR);
  assign isDiv = isRtype && (funct == `FN_DIV);
  assign isMove = isRtype && (funct == `FN_MFHI || funct == `FN_MFLO);

  // ALU operation for the execute step
  always_comb begin
    execOp = ADD; // addi
    if (isRtype) begin
      case (funct)
        `FN_SUB: execOp = SUB;
        `FN_AND: execOp = AND;
        `FN_SLT: execOp = SLT;
        default: execOp = ADD;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state <= RESET;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    irWe = 1'b0;
    pcWe = 1'b0;
    abWe = 1'b0;
    aluOutWe = 1'b0;
    hiLoWe = 1'b0;
    regWe = 1'b0;
    divStart = 1'b0;
    pcSel = PC_PLUS4;
    srcASel = 1'b0; // PC
    srcBSel = SRCB_REG;
    wbSel = WB_ALU;
    aluOp = PASS_A;
    case (state)
      RESET: nextState = FETCH0;
      FETCH0: begin
        irWe = 1'b1;
        srcBSel = SRCB_FOUR;
        aluOp = ADD; // PC+4 into ALUOut
        aluOutWe = 1'b1;
        nextState = FETCH1;
      end
      FETCH1: nextState = DECODE;
      DECODE: begin
        pcWe = 1'b1;
        if (isJ || isJal) begin
          pcSel = PC_JUMP;
          nextState = JUMP;
        end else if (isAddi || isAluR || isJr || isDiv) begin
          nextState = READREGS;
        end else if (isMove) begin
          nextState = MOVEHILO;
        end else begin
          nextState = FETCH0; // Unsupported code, no-op
        end
      end
      READREGS: begin
        abWe = 1'b1;
        if (isDiv) begin
          nextState = DIVSTART;
        end else if (isJr) begin
          nextState = JUMP;
        end else begin
          nextState = EXECUTE;
        end
      end
      EXECUTE: begin
        srcASel = 1'b1;
        srcBSel = isAddi ? SRCB_IMM : SRCB_REG;
        aluOp = execOp;
        aluOutWe = 1'b1;
        nextState = WRITEBACK;
      end
      WRITEBACK: begin
        regWe = 1'b1;
        nextState = FETCH0;
      end
      JUMP: begin
        // j only idles here
        if (isJal) begin
          wbSel = WB_LINK;
          regWe = 1'b1;
        end else if (isJr) begin
          srcASel = 1'b1;
          pcSel = PC_REG;
          pcWe = 1'b1;
        end
        nextState = FETCH0;
      end
      DIVSTART: begin
        divStart = 1'b1;
        nextState = DIVWAIT;
      end
      DIVWAIT: if (divDone) nextState = DIVSAVE;
      DIVSAVE: begin
        hiLoWe = 1'b1;
        nextState = FETCH0;
      end
      MOVEHILO: begin
        wbSel = (funct == `FN_MFHI) ? WB_HI : WB_LO;
        regWe = 1'b1;
        nextState = FETCH0;
      end
      default: nextState = FETCH0;
    endcase
  end

endmodule

/* hw/datapathRegs.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module datapathRegs (
  input  logic              clk,
  input  logic              reset_in,
  input  cpu_pkg::word_t    instrData,
  input  logic              irWe,
  input  logic              pcWe,
  input  logic              abWe,
  input  logic              aluOutWe,
  input  logic              hiLoWe,
  input  cpu_pkg::pcSel_t   pcSel,
  input  logic              srcASel,
  input  cpu_pkg::srcBSel_t srcBSel,
  input  cpu_pkg::wbSel_t   wbSel,
  input  cpu_pkg::word_t    rsData,
  input  cpu_pkg::word_t    rtData,
  input  cpu_pkg::word_t    aluResult,
  input  cpu_pkg::word_t    quotient,
  input  cpu_pkg::word_t    remainder,
  output cpu_pkg::word_t    pc,
  output cpu_pkg::word_t    aluInA,
  output cpu_pkg::word_t    aluInB,
  output cpu_pkg::word_t    aReg,
  output cpu_pkg::word_t    bReg,
  output cpu_pkg::word_t    wbData,
  output cpu_pkg::opcode_t  opcode,
  output cpu_pkg::funct_t   funct,
  output cpu_pkg::regAddr_t rs,
  output cpu_pkg::regAddr_t rt,
  output cpu_pkg::regAddr_t wbAddr
);
  import cpu_pkg::*;

  word_t ir;
  word_t aluOut;
  word_t hiReg;
  word_t loReg;
  word_t immExt;
  word_t jumpTarget;
  word_t nextPc;
  regAddr_t rd;

  assign opcode = ir[31:26];
  assign rs = ir[25:21];
  assign rt = ir[20:16];
  assign rd = ir[15:11];
  assign funct = ir[5:0];
  assign immExt = {{16{ir[15]}}, ir[15:0]};
  assign jumpTarget = {pc[31:28], ir[25:0], 2'b00}; // Same 256 MB region

  always_ff @(posedge clk) begin
    if (reset_in) begin
      pc <= '0;
      ir <= '0;
    end else begin
      if (pcWe) pc <= nextPc;
      if (irWe) ir <= instrData;
    end
  end

  always_ff @(posedge clk) begin
    if (abWe) begin
      aReg <= rsData;
      bReg <= rtData;
    end
    if (aluOutWe) aluOut <= aluResult;
    if (hiLoWe) begin
      hiReg <= remainder;
      loReg <= quotient;
    end
  end

  assign aluInA = srcASel ? aReg : pc;

  always_comb begin
    case (srcBSel)
      SRCB_FOUR: aluInB = 32'd4;
      SRCB_IMM:  aluInB = immExt;
      default:   aluInB = bReg;
    endcase
    case (pcSel)
      PC_JUMP: nextPc = jumpTarget;
      PC_REG:  nextPc = aluResult; // jr through pass-A
      default: nextPc = aluOut;
    endcase
    case (wbSel)
      WB_HI:   wbData = hiReg;
      WB_LO:   wbData = loReg;
      default: wbData = aluOut; // Link value is the PC+4 left by fetch
    endcase
    if (wbSel == WB_LINK) begin
      wbAddr = `LINK_REG;
    end else if (opcode == `OP_ADDI) begin
      wbAddr = rt;
    end else begin
      wbAddr = rd;
    end
  end

endmodule

/* hw/regFile.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module regFile (
  input  logic              clk,
  input  logic              reset_in,
  input  cpu_pkg::regAddr_t rs,
  input  cpu_pkg::regAddr_t rt,
  input  cpu_pkg::regAddr_t wbAddr,
  input  logic              regWe,
  input  cpu_pkg::word_t    wbData,
  output cpu_pkg::word_t    rsData,
  output cpu_pkg::word_t    rtData
);
  import cpu_pkg::*;

  word_t regs [`REG_N];

  always_ff @(posedge clk) begin
    if (reset_in) begin
      for (int i = 0; i < `REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (regWe && (wbAddr != '0)) begin
      regs[wbAddr] <= wbData; // r0 stays zero
    end
  end

  assign rsData = regs[rs];
  assign rtData = regs[rt];

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::word_t  aluInA,
  input  cpu_pkg::word_t  aluInB,
  input  cpu_pkg::aluOp_t aluOp,
  output cpu_pkg::word_t  aluResult
);
  import cpu_pkg::*;

  logic lessThan;

  // Signed compare for slt
  assign lessThan = $signed(aluInA) < $signed(aluInB);

  always_comb begin
    case (aluOp)
      ADD:     aluResult = aluInA + aluInB;
      SUB:     aluResult = aluInA - aluInB;
      AND:     aluResult = aluInA & aluInB;
      SLT:     aluResult = word_t'(lessThan);
      default: aluResult = aluInA; // PASS_A
    endcase
  end

endmodule

/* hw/divider.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module divider (
  input  logic           clk,
  input  logic           reset_in,
  input  logic           divStart,
  input  cpu_pkg::word_t aReg,
  input  cpu_pkg::word_t bReg,
  output logic           divDone,
  output cpu_pkg::word_t quotient,
  output cpu_pkg::word_t remainder
);
  import cpu_pkg::*;

  logic busy;
  logic [5:0] stepCnt;
  logic negQuot;
  logic negRem;
  word_t quotMag;
  word_t remMag;
  word_t divisorMag;
  logic [`WORD_W:0] partial;
  logic [`WORD_W:0] trial;

  assign partial = {remMag, quotMag[`WORD_W-1]};
  assign trial = partial - {1'b0, divisorMag};

  always_ff @(posedge clk) begin
    if (reset_in) begin
      busy <= 1'b0;
      stepCnt <= '0;
      divDone <= 1'b0;
    end else begin
      divDone <= busy && (stepCnt == 6'd1); // Last step this cycle
      if (divStart) begin
        busy <= 1'b1;
        stepCnt <= 6'(`WORD_W);
      end else if (busy) begin
        stepCnt <= stepCnt - 6'd1;
        if (stepCnt == 6'd1) busy <= 1'b0;
      end
    end
  end

  // One restoring step per cycle on the magnitudes
  always_ff @(posedge clk) begin
    if (divStart) begin
      quotMag <= aReg[`WORD_W-1] ? -aReg : aReg;
      divisorMag <= bReg[`WORD_W-1] ? -bReg : bReg;
      remMag <= '0;
      negQuot <= aReg[`WORD_W-1] ^ bReg[`WORD_W-1];
      negRem <= aReg[`WORD_W-1];
    end else if (busy) begin
      if (!trial[`WORD_W]) begin
        remMag <= trial[`WORD_W-1:0];
        quotMag <= {quotMag[`WORD_W-2:0], 1'b1};
      end else begin
        remMag <= partial[`WORD_W-1:0];
        quotMag <= {quotMag[`WORD_W-2:0], 1'b0};
      end
    end
  end

  // Truncating division, remainder follows the dividend
  assign quotient = negQuot ? -quotMag : quotMag;
  assign remainder = negRem ? -remMag : remMag;

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore (
  input  logic              clk,
  input  logic              reset_in,
  input  cpu_pkg::word_t    instrData,
  output cpu_pkg::word_t    instrAddr,
  output logic              regWe,
  output cpu_pkg::regAddr_t regWaddr,
  output cpu_pkg::word_t    regWdata
);
  import cpu_pkg::*;

  opcode_t opcode;
  funct_t funct;
  logic irWe;
  logic pcWe;
  logic abWe;
  logic aluOutWe;
  logic hiLoWe;
  logic divStart;
  logic divDone;
  pcSel_t pcSel;
  logic srcASel;
  srcBSel_t srcBSel;
  wbSel_t wbSel;
  aluOp_t aluOp;
  regAddr_t rs;
  regAddr_t rt;
  word_t rsData;
  word_t rtData;
  word_t aluInA;
  word_t aluInB;
  word_t aluResult;
  word_t aReg;
  word_t bReg;
  word_t quotient;
  word_t remainder;

  controlUnit ctrl_i (
    .clk(clk), .reset_in(reset_in), .opcode(opcode), .funct(funct), .divDone(divDone),
    .irWe(irWe), .pcWe(pcWe), .abWe(abWe), .aluOutWe(aluOutWe), .hiLoWe(hiLoWe),
    .regWe(regWe), .divStart(divStart), .pcSel(pcSel), .srcASel(srcASel),
    .srcBSel(srcBSel), .wbSel(wbSel), .aluOp(aluOp)
  );

  // PC doubles as the fetch address, write port is the commit trace
  datapathRegs dp_i (
    .clk(clk), .reset_in(reset_in), .instrData(instrData), .irWe(irWe), .pcWe(pcWe),
    .abWe(abWe), .aluOutWe(aluOutWe), .hiLoWe(hiLoWe), .pcSel(pcSel), .srcASel(srcASel),
    .srcBSel(srcBSel), .wbSel(wbSel), .rsData(rsData), .rtData(rtData),
    .aluResult(aluResult), .quotient(quotient), .remainder(remainder), .pc(instrAddr),
    .aluInA(aluInA), .aluInB(aluInB), .aReg(aReg), .bReg(bReg), .wbData(regWdata),
    .opcode(opcode), .funct(funct), .rs(rs), .rt(rt), .wbAddr(regWaddr)
  );

  regFile rf_i (
    .clk(clk), .reset_in(reset_in), .rs(rs), .rt(rt), .wbAddr(regWaddr),
    .regWe(regWe), .wbData(regWdata), .rsData(rsData), .rtData(rtData)
  );

  alu alu_i (.aluInA(aluInA), .aluInB(aluInB), .aluOp(aluOp), .aluResult(aluResult));

  divider div_i (
    .clk(clk), .reset_in(reset_in), .divStart(divStart), .aReg(aReg), .bReg(bReg),
    .divDone(divDone), .quotient(quotient), .remainder(remainder)
  );

endmodule

/* bench/coreModel.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Instruction-level model of the kept ISA, one exp* entry per executed instruction
function automatic void runModel(int count);
  word_t regs [32];
  word_t hi;
  word_t lo;
  word_t pc;
  word_t instr;
  word_t nextPc;
  word_t simm;
  logic [5:0] op;
  logic [5:0] fn;
  logic [4:0] rs;
  logic [4:0] rt;
  logic [4:0] rd;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  hi = '0;
  lo = '0;
  pc = '0;
  for (int k = 0; k < count; k++) begin
    instr = imem[pc[9:2]];
    op = instr[31:26];
    rs = instr[25:21];
    rt = instr[20:16];
    rd = instr[15:11];
    fn = instr[5:0];
    simm = {{16{instr[15]}}, instr[15:0]};
    nextPc = pc + 4;
    expPc[k] = pc;
    expWe[k] = 1'b0;
    expWaddr[k] = '0;
    expWdata[k] = '0;
    expLat[k] = LAT_NOP; // Unknown codes fall back to fetch
    if (op == `OP_ADDI) begin
      expWe[k] = 1'b1;
      expWaddr[k] = rt;
      expWdata[k] = regs[rs] + simm;
      expLat[k] = LAT_ALU;
    end else if (op == `OP_J || op == `OP_JAL) begin
      nextPc = {nextPc[31:28], instr[25:0], 2'b00};
      expLat[k] = LAT_JUMP;
      if (op == `OP_JAL) begin
        expWe[k] = 1'b1;
        expWaddr[k] = `LINK_REG;
        expWdata[k] = pc + 4; // Return address
      end
    end else if (op == `OP_RTYPE) begin
      case (fn)
        `FN_ADD, `FN_SUB, `FN_AND, `FN_SLT: begin
          expWe[k] = 1'b1;
          expWaddr[k] = rd;
          expLat[k] = LAT_ALU;
          case (fn)
            `FN_ADD: expWdata[k] = regs[rs] + regs[rt];
            `FN_SUB: expWdata[k] = regs[rs] - regs[rt];
            `FN_AND: expWdata[k] = regs[rs] & regs[rt];
            default: expWdata[k] = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
          endcase
        end
        `FN_JR: begin
          nextPc = regs[rs];
          expLat[k] = LAT_JR;
        end
        `FN_DIV: begin
          // Truncates toward zero, remainder keeps the dividend's sign
          lo = $signed(regs[rs]) / $signed(regs[rt]);
          hi = $signed(regs[rs]) % $signed(regs[rt]);
          expLat[k] = LAT_DIV;
        end
        `FN_MFHI, `FN_MFLO: begin
          expWe[k] = 1'b1;
          expWaddr[k] = rd;
          expWdata[k] = (fn == `FN_MFHI) ? hi : lo;
          expLat[k] = LAT_MOVE;
        end
        default: expLat[k] = LAT_NOP;
      endcase
    end
    if (expWe[k] && expWaddr[k] != 0) begin
      regs[expWaddr[k]] = expWdata[k]; // r0 never changes
    end
    pc = nextPc;
  end
endfunction

`endif

/* bench/coreTb.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module coreTb;
  import cpu_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_INSTR = 40; // Covers a div
  localparam int SEED = 75;
  localparam int MEM_WORDS = 256;
  localparam int MAX_INSTR = 128;
  localparam int SUB_WORD = 200; // Subroutine for the call test
  localparam int DIV_CYCLES = 33;
  localparam int LAT_NOP = 3;
  localparam int LAT_ALU = 6;
  localparam int LAT_JUMP = 4;
  localparam int LAT_JR = 5;
  localparam int LAT_MOVE = 4;
  localparam int LAT_DIV = 5 + DIV_CYCLES + 1; // Up to DIVSTART, wait, DIVSAVE

  logic clk;
  logic reset_in;
  word_t instrData;
  word_t instrAddr;
  logic regWe;
  regAddr_t regWaddr;
  word_t regWdata;

  word_t imem [MEM_WORDS];
  int testOf [MEM_WORDS];
  string testName [6] = '{"reset", "alu", "zero reg", "jump", "call return", "div"};
  word_t expPc [MAX_INSTR];
  logic expWe [MAX_INSTR];
  regAddr_t expWaddr [MAX_INSTR];
  word_t expWdata [MAX_INSTR];
  int expLat [MAX_INSTR];
  int nInstr;
  int wrIdx;
  int execCount;
  int curTest;
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int cycleLimit;

  `include "coreModel.svh"

  mipsCore dut_i (
    .clk(clk), .reset_in(reset_in), .instrData(instrData), .instrAddr(instrAddr),
    .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata)
  );

  assign instrData = imem[instrAddr[9:2]]; // Combinational instruction memory

  always #5 clk = ~clk;

  function automatic word_t rType(int rs, int rt, int rd, logic [5:0] fn);
    return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic word_t iType(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t jType(logic [5:0] op, int target);
    word_t t;
    t = target;
    return {op, t[27:2]};
  endfunction

  // Word that is never executed
  task automatic place(word_t w);
    imem[wrIdx] = w;
    testOf[wrIdx] = curTest;
    wrIdx++;
  endtask

  task automatic emit(word_t w);
    place(w);
    execCount++;
  endtask

  task automatic emitRandomAlu();
    logic [5:0] fn;
    int rs;
    int rt;
    int rd;
    case ($urandom % 4)
      0: fn = `FN_ADD;
      1: fn = `FN_SUB;
      2: fn = `FN_AND;
      default: fn = `FN_SLT;
    endcase
    rs = 1 + $urandom % 15;
    rt = 1 + $urandom % 15;
    rd = 1 + $urandom % 15;
    emit(rType(rs, rt, rd, fn));
  endtask

  task automatic buildProgram();
    int saved;
    int target;
    int a;
    int b;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = 32'hFC00_0000 | i; // Opcode 3F runs as a no-op
      testOf[i] = -1;
    end
    wrIdx = 0;
    execCount = 0;
    curTest = 0;
    emit(iType(`OP_ADDI, 0, 1, -100));
    curTest = 1;
    emit(iType(`OP_ADDI, 0, 2, 50));
    for (int r = 3; r <= 15; r++) begin
      emit(iType(`OP_ADDI, 0, r, $urandom % 65536));
    end
    emit(rType(1, 2, 3, `FN_SLT)); // Negative against positive
    emit(rType(2, 1, 4, `FN_SLT));
    repeat (20) emitRandomAlu();
    curTest = 2;
    emit(iType(`OP_ADDI, 0, 0, 'h1234));
    emit(rType(0, 0, 5, `FN_ADD));
    emit(iType(`OP_ADDI, 0, 6, 7));
    curTest = 3;
    target = (wrIdx + 2) * 4;
    emit(jType(`OP_J, target));
    place(iType(`OP_ADDI, 0, 7, 'h99));
    emit(jType(`OP_JAL, SUB_WORD * 4));
    curTest = 4;
    emit(iType(`OP_ADDI, 0, 8, 1)); // Return point
    target = (wrIdx + 3) * 4;
    emit(iType(`OP_ADDI, 0, 9, target));
    emit(rType(9, 0, 0, `FN_JR));
    place(iType(`OP_ADDI, 0, 8, 'h77));
    emit(rType(8, 9, 10, `FN_ADD));
    saved = wrIdx;
    wrIdx = SUB_WORD;
    emit(rType(31, 0, 0, `FN_JR));
    wrIdx = saved;
    curTest = 5;
    repeat (8) begin
      a = int'($urandom % 65536) - 32768;
      b = int'($urandom % 32767) + 1;
      if ($urandom % 2) b = -b;
      emit(iType(`OP_ADDI, 0, 10, a));
      emit(iType(`OP_ADDI, 0, 11, b));
      emit(rType(10, 11, 0, `FN_DIV));
      emit(rType(0, 0, 12, `FN_MFHI));
      emit(rType(0, 0, 13, `FN_MFLO));
    end
    place(jType(`OP_J, wrIdx * 4)); // Parks the core
  endtask

  task automatic compareValue(string name, word_t got, word_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED %0s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  initial begin : stimulus
    clk = 1'b0;
    reset_in = 1'b1;
    void'($urandom(SEED));
    buildProgram();
    nInstr = execCount;
    runModel(nInstr);
    cycleLimit = RESET_CYCLES + CYCLES_PER_INSTR * nInstr;
    repeat (RESET_CYCLES) @(negedge clk);
    reset_in = 1'b0;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the core stalled and did not finish within %0d cycles", cycleLimit);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin : compare
    int cyc;
    int id;
    int testStartErrors;
    int passedTests;
    int failedTests;
    bit lastOfTest;
    passedTests = 0;
    failedTests = 0;
    testStartErrors = errorCount;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      compareValue("regWe", regWe, 1'b0);
    end
    @(negedge clk); // First FETCH0
    for (int k = 0; k < nInstr; k++) begin
      compareValue("instrAddr", instrAddr, expPc[k]);
      if (expWe[k]) begin
        cyc = 0;
        while (regWe !== 1'b1) begin
          @(negedge clk);
          cyc++;
        end
        compareValue("regWe cycle", cyc, expLat[k] - 1);
        compareValue("regWaddr", regWaddr, expWaddr[k]);
        compareValue("regWdata", regWdata, expWdata[k]);
        @(negedge clk);
      end else begin
        repeat (expLat[k]) begin
          compareValue("regWe", regWe, 1'b0);
          @(negedge clk);
        end
      end
      id = testOf[expPc[k][9:2]];
      lastOfTest = (k == nInstr - 1);
      if (!lastOfTest) lastOfTest = (testOf[expPc[k + 1][9:2]] != id);
      if (lastOfTest) begin
        if (errorCount == testStartErrors) passedTests++;
        else failedTests++;
        $display("Test %0s finished with %0d errors", testName[id],
                 errorCount - testStartErrors);
        testStartErrors = errorCount;
      end
    end
    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             passedTests, failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+hw
+incdir+bench
hw/cpu_pkg.sv
hw/controlUnit.sv
hw/datapathRegs.sv
hw/regFile.sv
hw/alu.sv
hw/divider.sv
hw/mipsCore.sv
bench/coreTb.sv
